// ==== filelist.f ====
hdl/ipu_pkg.sv
hdl/image_mem.sv
hdl/view_state.sv
hdl/op_sequencer.sv
hdl/ipu_core.sv
testbench/ipu_asserts.sv
testbench/ipu_tb.sv

// ==== Bender.yml ====
package:
  name: ipu_core

sources:
  # package first, then the design
  - hdl/ipu_pkg.sv
  - hdl/image_mem.sv
  - hdl/view_state.sv
  - hdl/op_sequencer.sv
  - hdl/ipu_core.sv

  # testbench
  - target: simulation
    files:
      - testbench/ipu_asserts.sv
      - testbench/ipu_tb.sv

// ==== testbench/ipu_tb.sv ====
`timescale 1ns/1ps

module ipu_tb import ipu_pkg::*; ();

    logic                i_clk;
    logic                i_rst_n;
    logic                i_op_valid;
    logic [3:0]          i_op_mode;
    logic                i_in_valid;
    logic [PIX_BITS-1:0] i_in_data;
    logic                o_op_ready;
    logic                o_in_ready;
    logic                o_out_valid;
    logic [OUT_BITS-1:0] o_out_data;

    // reference model of the image and the view
    logic [PIX_BITS-1:0] model [IMG_PIX];  // raster order c*64 + y*8 + x
    int                  org_x;
    int                  org_y;
    int                  chans;            // 8, 16 or 32 channels shown
    logic [OUT_BITS-1:0] exp_q [$];        // words still due from DISPLAY

    logic [31:0] seed = 32'd45;
    string       cur_test;
    int          errors;
    int          checks;
    int          tests;
    int          test_base;                // error count when the test started
    int          words;                    // words seen in the current DISPLAY
    int          runs;                     // separate o_out_valid bursts
    logic        prev_valid;

    ipu_core dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;  // 4 ns period
    end

    // --------------------------------------------------------------------------
    // helpers
    // --------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // pos 0..3 walks (x,y) (x+1,y) (x,y+1) (x+1,y+1)
    function automatic logic [OUT_BITS-1:0] expected_pixel(input int ch, input int pos);
        int x;
        int y;
        x = org_x + (pos % 2);
        y = org_y + (pos / 2);
        return OUT_BITS'(model[ch * IMG_W * IMG_H + y * IMG_W + x]);
    endfunction

    task automatic check_value(input string name, input int exp_v, input int act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("error %s, %s: expected %0d, actual %0d", cur_test, name, exp_v, act_v);
        end
    endtask

    task automatic wait_op_ready(input string what, input int limit, output int lat);
        lat = 0;
        do begin
            @(negedge i_clk);
            lat++;
        end while (!o_op_ready && lat < limit);
        if (!o_op_ready) begin
            errors++;
            $display("timeout in %s: o_op_ready never pulsed after %s", cur_test, what);
        end
    endtask

    // one-cycle offer that returns on the falling edge after the accepting edge
    task automatic issue_op(input logic [3:0] op);
        @(negedge i_clk);
        i_op_valid = 1'b1;
        i_op_mode  = op;
        @(negedge i_clk);
        i_op_valid = 1'b0;
    endtask

    task automatic view_op(input logic [3:0] op);
        int lat;
        issue_op(op);
        case (op)  // clamped model steps
            OP_ORG_R:   if (org_x < ORG_MAX) org_x++;
            OP_ORG_L:   if (org_x > 0) org_x--;
            OP_ORG_U:   if (org_y > 0) org_y--;
            OP_ORG_D:   if (org_y < ORG_MAX) org_y++;
            OP_SCALE_D: if (chans > 8) chans = chans / 2;
            OP_SCALE_U: if (chans < 32) chans = chans * 2;
            default:    ;
        endcase
        wait_op_ready("view op", 10, lat);
        check_value("view op ready latency", 2, lat);
    endtask

    task automatic load_image();
        int          n;
        int          guard;
        int          lat;
        logic [31:0] r;
        issue_op(OP_LOAD);
        n     = 0;
        guard = 0;
        while (o_in_ready && guard < 4 * IMG_PIX) begin
            r          = lcg_next();
            i_in_valid = (r[31:30] != 2'b00);  // about one gap in four
            i_in_data  = r[23:16];
            if (i_in_valid && n < IMG_PIX) begin
                model[n] = i_in_data;
            end
            @(negedge i_clk);
            if (i_in_valid) n++;              // o_in_ready was high at that edge
            guard++;
        end
        i_in_valid = 1'b0;
        if (o_in_ready) begin
            errors++;
            $display("timeout in %s: o_in_ready stayed high during LOAD", cur_test);
        end
        check_value("pixels accepted", IMG_PIX, n);
        wait_op_ready("LOAD", 4, lat);
        check_value("load ready latency", 1, lat);
    endtask

    task automatic display();
        int lat;
        for (int ch = 0; ch < chans; ch++) begin
            for (int pos = 0; pos < 4; pos++) begin
                exp_q.push_back(expected_pixel(ch, pos));
            end
        end
        words = 0;
        runs  = 0;
        issue_op(OP_DISPLAY);
        lat = 0;
        while (!o_out_valid && lat < 2) begin  // lead-in of one or two cycles
            @(negedge i_clk);
            lat++;
        end
        if (!o_out_valid) begin
            errors++;
            $display("timeout in %s: o_out_valid did not rise within two cycles of DISPLAY",
                     cur_test);
        end
        // valid for every word, then ready one cycle after it falls
        wait_op_ready("DISPLAY", 200, lat);
        check_value("display ready latency", 4 * chans + 1, lat);
        check_value("display word count", 4 * chans, words);
        check_value("display bursts", 1, runs);
        exp_q.delete();
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_base = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", cur_test, errors - test_base);
    endtask

    // --------------------------------------------------------------------------
    // comparing process sampled mid-cycle
    // --------------------------------------------------------------------------
    initial begin
        prev_valid = 1'b0;
        forever begin
            @(negedge i_clk);
            if (o_out_valid) begin
                if (!prev_valid) runs++;
                words++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("output word %0d arrived in %s with none expected",
                             o_out_data, cur_test);
                end else begin
                    check_value($sformatf("display word %0d", words - 1),
                                exp_q.pop_front(), o_out_data);
                end
            end
            prev_valid = o_out_valid;
        end
    end

    // --------------------------------------------------------------------------
    // stimulus
    // --------------------------------------------------------------------------
    initial begin
        int          lat;
        logic [31:0] r;
        i_rst_n    = 1'b0;
        i_op_valid = 1'b0;
        i_op_mode  = '0;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        org_x      = 0;
        org_y      = 0;
        chans      = 32;  // full depth after reset
        errors     = 0;
        checks     = 0;
        tests      = 0;
        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;

        start_test("startup");
        wait_op_ready("reset", 10, lat);
        check_value("first ready edge", 3, lat);
        check_value("in ready after reset", 0, o_in_ready);
        lat = 0;
        repeat (10) begin
            @(negedge i_clk);
            if (o_op_ready) lat++;
        end
        check_value("extra ready pulses", 0, lat);
        load_image();
        display();
        end_test();

        start_test("origin");
        repeat (8) view_op(OP_ORG_R);  // pushes past 6
        repeat (8) view_op(OP_ORG_D);
        display();
        repeat (8) view_op(OP_ORG_L);  // back past 0
        repeat (8) view_op(OP_ORG_U);
        display();
        repeat (3) begin
            repeat (12) begin
                r = lcg_next();
                view_op(4'd1 + {2'b00, r[31:30]});
            end
            display();
        end
        end_test();

        start_test("depth");
        repeat (3) begin
            view_op(OP_SCALE_D);  // 16 then 8 then held at 8
            display();
        end
        repeat (3) begin
            view_op(OP_SCALE_U);  // 16 then 32 then held at 32
            display();
        end
        end_test();

        start_test("ignored");
        for (int k = 8; k < 16; k++) begin
            issue_op(4'(k));
            lat = 0;
            repeat (20) begin
                @(negedge i_clk);
                if (o_op_ready) lat++;
            end
            check_value($sformatf("ready pulses after opcode %0d", k), 0, lat);
        end
        display();
        end_test();

        start_test("reload");
        load_image();
        display();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== testbench/ipu_asserts.sv ====
`timescale 1ns/1ps

module ipu_asserts import ipu_pkg::*; (
    input logic                i_clk,
    input logic                i_rst_n,
    input logic                i_op_ready,
    input logic                i_in_ready,
    input logic                i_out_valid,
    input logic [OUT_BITS-1:0] i_out_data
);

    // ready is a single-cycle pulse
    a_ready_pulse : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_op_ready |=> !i_op_ready)
        else $error("o_op_ready high for two cycles");

    // load and display never overlap
    a_in_out_excl : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_in_ready && i_out_valid))
        else $error("o_in_ready and o_out_valid high together");

    // pixel is zero-extended
    a_out_upper : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid |-> (i_out_data[OUT_BITS-1:PIX_BITS] == '0))
        else $error("o_out_data upper bits not zero");

endmodule

// attached to every ipu_core instance
bind ipu_core ipu_asserts asserts_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_op_ready  (o_op_ready),
    .i_in_ready  (o_in_ready),
    .i_out_valid (o_out_valid),
    .i_out_data  (o_out_data)
);

// ==== hdl/ipu_core.sv ====
`timescale 1ns/1ps

module ipu_core import ipu_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,       // async, active low
    input  logic                i_op_valid,    // op offered this cycle
    input  logic [3:0]          i_op_mode,     // raw opcode, 8..15 ignored
    input  logic                i_in_valid,    // pixel offered (LOAD)
    input  logic [PIX_BITS-1:0] i_in_data,
    output logic                o_op_ready,    // one-cycle pulse
    output logic                o_in_ready,    // level during LOAD
    output logic                o_out_valid,   // DISPLAY stream, no back-pressure
    output logic [OUT_BITS-1:0] o_out_data
);

    // ------------------------------------------------------------------------
    // internal links
    // ------------------------------------------------------------------------
    mem_req_t            mem_req;   // sequencer -> pixel store
    logic [PIX_BITS-1:0] mem_rdata; // pixel store -> sequencer, 1 cycle later
    view_cmd_t           view_cmd;  // update strobes
    view_t               view;      // origin and depth

    // control
    op_sequencer seq_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_mode   (opcode_e'(i_op_mode)),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .i_view      (view),
        .i_rdata     (mem_rdata),
        .o_view_cmd  (view_cmd),
        .o_mem_req   (mem_req),
        .o_op_ready  (o_op_ready),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    // four-bank image store
    image_mem mem_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (mem_req),
        .o_rdata (mem_rdata)
    );

    // origin and depth registers
    view_state view_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (view_cmd),
        .o_view  (view)
    );

endmodule

// ==== hdl/op_sequencer.sv ====
`timescale 1ns/1ps

module op_sequencer import ipu_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_op_valid,
    input  opcode_e             i_op_mode,
    input  logic                i_in_valid,
    input  logic [PIX_BITS-1:0] i_in_data,
    input  view_t               i_view,
    input  logic [PIX_BITS-1:0] i_rdata,
    output view_cmd_t           o_view_cmd,
    output mem_req_t            o_mem_req,
    output logic                o_op_ready,
    output logic                o_in_ready,
    output logic                o_out_valid,
    output logic [OUT_BITS-1:0] o_out_data
);

    typedef enum logic [3:0] {
        S_RST0,    // startup wait
        S_RST1,
        S_RST2,    // leaving here gives the first ready pulse
        S_IDLE,
        S_LOAD,
        S_VIEW,    // view_state takes the strobe
        S_DISP,    // one read per cycle
        S_DRAIN,   // last word on the output
        S_FINISH   // ready pulse on the way out
    } state_e;

    state_e state;

    pix_addr_u                load_addr;   // raster count while loading
    logic                     load_fire;
    logic [$clog2(IMG_C)-1:0] disp_c;      // channel being walked
    logic [1:0]               disp_xy;     // bit0 -> x+1, bit1 -> y+1
    logic                     disp_end;
    view_cmd_t                op_cmd;      // decoded strobe for a view op

    // ------------------------------------------------------------------------
    // opcode decode for origin and depth ops
    // ------------------------------------------------------------------------
    always_comb begin
        op_cmd = '0;
        case (i_op_mode)
            OP_ORG_R:   op_cmd.org_r   = 1'b1;
            OP_ORG_L:   op_cmd.org_l   = 1'b1;
            OP_ORG_U:   op_cmd.org_u   = 1'b1;
            OP_ORG_D:   op_cmd.org_d   = 1'b1;
            OP_SCALE_D: op_cmd.scale_d = 1'b1;
            OP_SCALE_U: op_cmd.scale_u = 1'b1;
            default:    op_cmd         = '0;
        endcase
    end

    assign load_fire = o_in_ready && i_in_valid;                  // one pixel per beat
    assign disp_end  = (disp_xy == 2'd3) && (disp_c == depth_last(i_view.depth));

    // ------------------------------------------------------------------------
    // memory request, writes while loading, walker reads while displaying
    // ------------------------------------------------------------------------
    always_comb begin
        o_mem_req = '0;
        if (load_fire) begin
            o_mem_req.en    = 1'b1;
            o_mem_req.we    = 1'b1;
            o_mem_req.addr  = load_addr;
            o_mem_req.wdata = i_in_data;
        end else if (state == S_DISP) begin
            o_mem_req.en               = 1'b1;
            o_mem_req.addr.coord.channel = disp_c;
            o_mem_req.addr.coord.y     = i_view.origin_y + {2'b00, disp_xy[1]};
            o_mem_req.addr.coord.x     = i_view.origin_x + {2'b00, disp_xy[0]};
        end
    end

    // read data lands while o_out_valid is up
    assign o_out_data = {{(OUT_BITS - PIX_BITS){1'b0}}, i_rdata};

    // ------------------------------------------------------------------------
    // main sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= S_RST0;
            load_addr   <= '0;
            disp_c      <= '0;
            disp_xy     <= '0;
            o_view_cmd  <= '0;
            o_op_ready  <= 1'b0;
            o_in_ready  <= 1'b0;
            o_out_valid <= 1'b0;
        end else begin
            o_op_ready  <= 1'b0;                 // pulses only
            o_view_cmd  <= '0;                   // strobes only
            o_out_valid <= (state == S_DISP);    // one cycle behind the read

            case (state)
                S_RST0: state <= S_RST1;
                S_RST1: state <= S_RST2;
                S_RST2: begin
                    o_op_ready <= 1'b1;
                    state      <= S_IDLE;
                end

                S_IDLE: begin
                    if (i_op_valid) begin
                        case (i_op_mode)
                            OP_LOAD: begin
                                load_addr  <= '0;
                                o_in_ready <= 1'b1;
                                state      <= S_LOAD;
                            end
                            OP_ORG_R, OP_ORG_L, OP_ORG_U, OP_ORG_D,
                            OP_SCALE_D, OP_SCALE_U: begin
                                o_view_cmd <= op_cmd;
                                state      <= S_VIEW;
                            end
                            OP_DISPLAY: begin
                                disp_c  <= '0;
                                disp_xy <= '0;
                                state   <= S_DISP;
                            end
                            default: state <= S_IDLE;  // unsupported, no pulse
                        endcase
                    end
                end

                S_LOAD: begin
                    if (load_fire) begin
                        load_addr.raster <= load_addr.raster + 1'b1;
                        if (load_addr.raster == IMG_PIX - 1) begin
                            o_in_ready <= 1'b0;  // last pixel just written
                            state      <= S_FINISH;
                        end
                    end
                end

                S_VIEW: state <= S_FINISH;   // view settled this edge

                // 2x2 position first, then channel
                S_DISP: begin
                    disp_xy <= disp_xy + 2'd1;
                    if (disp_xy == 2'd3) begin
                        disp_c <= disp_c + 1'b1;
                    end
                    if (disp_end) begin
                        state <= S_DRAIN;
                    end
                end

                S_DRAIN: state <= S_FINISH;  // o_out_valid drops here

                S_FINISH: begin
                    o_op_ready <= 1'b1;
                    state      <= S_IDLE;
                end

                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/view_state.sv ====
`timescale 1ns/1ps

module view_state import ipu_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  view_cmd_t i_cmd,
    output view_t     o_view
);

    view_t view_q;
    view_t view_d;

    // ------------------------------------------------------------------------
    // clamped steps, a step that would leave the range is dropped
    // ------------------------------------------------------------------------
    always_comb begin
        view_d = view_q;

        // horizontal
        if (i_cmd.org_r && (view_q.origin_x < ORG_MAX)) begin
            view_d.origin_x = view_q.origin_x + 3'd1;
        end
        if (i_cmd.org_l && (view_q.origin_x != '0)) begin
            view_d.origin_x = view_q.origin_x - 3'd1;
        end

        // vertical, up is toward row 0
        if (i_cmd.org_u && (view_q.origin_y != '0)) begin
            view_d.origin_y = view_q.origin_y - 3'd1;
        end
        if (i_cmd.org_d && (view_q.origin_y < ORG_MAX)) begin
            view_d.origin_y = view_q.origin_y + 3'd1;
        end

        // depth walks 8 <-> 16 <-> 32
        if (i_cmd.scale_d && (view_q.depth != DEPTH_8)) begin
            view_d.depth = depth_e'(view_q.depth - 2'd1);
        end
        if (i_cmd.scale_u && (view_q.depth != DEPTH_32)) begin
            view_d.depth = depth_e'(view_q.depth + 2'd1);
        end
    end

    // ------------------------------------------------------------------------
    // state register
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            view_q.origin_x <= '0;       // origin (0,0)
            view_q.origin_y <= '0;
            view_q.depth    <= DEPTH_32; // full depth after reset
        end else begin
            view_q <= view_d;            // takes effect the edge after the strobe
        end
    end

    assign o_view = view_q;

endmodule

// ==== hdl/image_mem.sv ====
`timescale 1ns/1ps

module image_mem import ipu_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mem_req_t            i_req,
    output logic [PIX_BITS-1:0] o_rdata
);

    // ------------------------------------------------------------------------
    // address split
    // ------------------------------------------------------------------------
    logic [BANK_BITS-1:0] bank;      // low channel bits pick the bank
    logic [OFF_BITS-1:0]  offset;    // upper channel bits, row, column
    logic [BANK_BITS-1:0] bank_q;    // bank of the read in flight

    logic [PIX_BITS-1:0] bank_rdata [BANK_COUNT];

    assign bank   = i_req.addr.coord.channel[BANK_BITS-1:0];
    assign offset = {i_req.addr.coord.channel[$bits(i_req.addr.coord.channel)-1:BANK_BITS],
                     i_req.addr.coord.y,
                     i_req.addr.coord.x};

    // ------------------------------------------------------------------------
    // banks
    // ------------------------------------------------------------------------
    for (genvar gb = 0; gb < BANK_COUNT; gb++) begin : g_bank
        logic [PIX_BITS-1:0] mem [BANK_DEPTH];
        logic                hit;

        assign hit = i_req.en && (bank == BANK_BITS'(gb));

        always_ff @(posedge i_clk) begin
            if (hit && i_req.we) begin
                mem[offset] <= i_req.wdata;  // synchronous write
            end
        end

        // output register per bank, only loads on its own reads
        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                bank_rdata[gb] <= '0;
            end else if (hit && !i_req.we) begin
                bank_rdata[gb] <= mem[offset];
            end
        end
    end

    // remember which bank answers next cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bank_q <= '0;
        end else if (i_req.en && !i_req.we) begin
            bank_q <= bank;
        end
    end

    assign o_rdata = bank_rdata[bank_q];  // one edge after the request

endmodule

// ==== hdl/ipu_pkg.sv ====
package ipu_pkg;

    // ------------------------------------------------------------------------
    // image geometry
    // ------------------------------------------------------------------------
    localparam int IMG_W   = 8;                      // columns
    localparam int IMG_H   = 8;                      // rows
    localparam int IMG_C   = 32;                     // channels
    localparam int IMG_PIX = IMG_W * IMG_H * IMG_C;  // 2048 pixels per image

    // banked pixel store, 4 x 512 bytes
    localparam int BANK_COUNT = 4;
    localparam int BANK_BITS  = 2;   // log2(BANK_COUNT)
    localparam int BANK_DEPTH = 512;
    localparam int OFF_BITS   = 9;   // log2(BANK_DEPTH)
    localparam int PIX_BITS   = 8;   // unsigned pixel
    localparam int OUT_BITS   = 14;  // output word, pixel zero-extended

    // largest origin, keeps the 2x2 window inside the image
    localparam int ORG_MAX = 6;

    // ------------------------------------------------------------------------
    // opcodes and depth codes
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        OP_LOAD    = 4'd0,
        OP_ORG_R   = 4'd1,  // origin x + 1
        OP_ORG_L   = 4'd2,  // origin x - 1
        OP_ORG_U   = 4'd3,  // origin y - 1
        OP_ORG_D   = 4'd4,  // origin y + 1
        OP_SCALE_D = 4'd5,  // fewer channels
        OP_SCALE_U = 4'd6,  // more channels
        OP_DISPLAY = 4'd7
    } opcode_e;  // 8..15 not carried out

    typedef enum logic [1:0] {
        DEPTH_8  = 2'd0,
        DEPTH_16 = 2'd1,
        DEPTH_32 = 2'd2   // reset default
    } depth_e;

    // ------------------------------------------------------------------------
    // pixel index, raster count or channel/row/column
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [$clog2(IMG_C)-1:0] channel;
        logic [$clog2(IMG_H)-1:0] y;
        logic [$clog2(IMG_W)-1:0] x;
    } pix_coord_t;

    // raster = channel*64 + y*8 + x, so both views share the same bits
    typedef union packed {
        logic [$clog2(IMG_PIX)-1:0] raster;
        pix_coord_t                 coord;
    } pix_addr_u;

    // current view, owned by view_state
    typedef struct packed {
        logic [$clog2(IMG_W)-1:0] origin_x;
        logic [$clog2(IMG_H)-1:0] origin_y;
        depth_e                   depth;
    } view_t;

    // one-cycle update strobes, at most one set
    typedef struct packed {
        logic org_r;
        logic org_l;
        logic org_u;
        logic org_d;
        logic scale_d;
        logic scale_u;
    } view_cmd_t;

    // single port request into the pixel store
    typedef struct packed {
        logic                en;
        logic                we;     // 1 write, 0 read
        pix_addr_u           addr;
        logic [PIX_BITS-1:0] wdata;
    } mem_req_t;

    // last channel shown for a depth code
    function automatic logic [$clog2(IMG_C)-1:0] depth_last(depth_e d);
        case (d)
            DEPTH_8:  return 5'd7;
            DEPTH_16: return 5'd15;
            default:  return 5'd31;
        endcase
    endfunction

endpackage
